// ==== dcache.f ====
dcache_pkg.sv
dcache_sets.sv
dcache_ctrl.sv
line_mem.sv
dcache_top.sv
dcache_assertions.sv
dcache_tb.sv

// ==== Makefile ====
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --top-module $(TOP) -f dcache.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== dcache_tb.sv ====
module dcache_tb;
	import dcache_pkg::*;

	localparam int N_ACCESSES      = 348;   // sum over all tests below
	localparam int WATCHDOG_CYCLES = N_ACCESSES * 200 + 20;

	logic              clk;
	logic              rst;
	logic              i_re;
	logic              i_we;
	logic [ADDR_W-1:0] i_addr;
	logic [WORD_W-1:0] i_wdata;
	logic [WORD_W-1:0] o_rdata;
	logic              o_hit;

	logic [WORD_W-1:0] ref_mem [2**ADDR_W];   // expected contents by word address
	logic [31:0]       rng_state;

	dcache_top dcache_top_i (
		.clk     (clk),
		.rst     (rst),
		.i_re    (i_re),
		.i_we    (i_we),
		.i_addr  (i_addr),
		.i_wdata (i_wdata),
		.o_rdata (o_rdata),
		.o_hit   (o_hit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ends a run that stops making progress
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired, the cache never finished its accesses");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
			input logic [INDEX_W-1:0] index, input logic [OFFSET_W-1:0] offset);
		return {tag, index, offset};
	endfunction

	task automatic report_mismatch(input string name, input logic [WORD_W-1:0] exp,
			input logic [WORD_W-1:0] act);
		$display("ERROR %s: expected %h, actual %h", name, exp, act);
		$display("=== FAIL ===");
		$fatal(1, "check failed in %s", name);
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		assert (act === exp) else report_mismatch(name, {15'd0, exp}, {15'd0, act});
	endtask

	// one access held until the cache answers with o_hit
	task automatic run_access(input logic is_write, input logic [ADDR_W-1:0] addr,
			input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata,
			output logic first_hit);
		int wait_cycles;
		@(negedge clk);
		i_re    = !is_write;
		i_we    = is_write;
		i_addr  = addr;
		i_wdata = wdata;
		wait_cycles = 0;
		#1;
		while (!o_hit) begin
			@(negedge clk);
			#1;
			wait_cycles++;
		end
		rdata     = o_rdata;   // read data valid in the completing cycle
		first_hit = (wait_cycles == 0);
		@(posedge clk);        // write commits here
		@(negedge clk);
		i_re = 1'b0;
		i_we = 1'b0;
	endtask

	task automatic do_read(input string name, input logic [ADDR_W-1:0] addr,
			output logic first_hit);
		logic [WORD_W-1:0] got;
		run_access(1'b0, addr, '0, got, first_hit);
		assert (got === ref_mem[addr]) else report_mismatch(name, ref_mem[addr], got);
	endtask

	task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		logic [WORD_W-1:0] unused_rdata;
		logic              unused_first;
		run_access(1'b1, addr, data, unused_rdata, unused_first);
		ref_mem[addr] = data;
	endtask

	task automatic test_after_reset();
		logic first;
		@(negedge clk);
		#1;
		check_flag("after_reset idle hit", 1'b1, o_hit);
		do_read("after_reset", 16'h0000, first);
		do_read("after_reset", 16'h4567, first);
		do_read("after_reset", 16'hffff, first);
		do_read("after_reset", 16'h8001, first);
	endtask

	task automatic test_store_reload();
		logic [ADDR_W-1:0] addrs [8];
		logic              first;
		for (int i = 0; i < 8; i++) begin
			rng_state = xorshift(rng_state);
			addrs[i]  = rng_state[15:0];
			do_write(addrs[i], rng_state[31:16]);
			do_read("store_reload", addrs[i], first);
			check_flag("store_reload first-cycle hit", 1'b1, first);
		end
		for (int i = 0; i < 8; i++) begin
			do_read("store_reload later", addrs[i], first);
		end
	endtask

	task automatic test_word_merge();
		logic first;
		for (int w = 0; w < 4; w++) begin
			rng_state = xorshift(rng_state);
			do_write(16'h1230 | 16'(w), rng_state[15:0]);
		end
		for (int w = 0; w < 4; w++) begin
			do_read("word_merge", 16'h1230 | 16'(w), first);
		end
	endtask

	task automatic test_lru_choice();
		logic first;
		do_read("lru A", make_addr(9'd1, 5'd3, 2'd0), first);
		do_read("lru B", make_addr(9'd2, 5'd3, 2'd0), first);
		do_read("lru A again", make_addr(9'd1, 5'd3, 2'd0), first);
		do_read("lru C", make_addr(9'd3, 5'd3, 2'd0), first);   // must replace B
		do_read("lru A kept", make_addr(9'd1, 5'd3, 2'd0), first);
		check_flag("lru A first-cycle hit", 1'b1, first);
		do_read("lru B evicted", make_addr(9'd2, 5'd3, 2'd0), first);
		check_flag("lru B first-cycle hit", 1'b0, first);
	endtask

	task automatic test_dirty_eviction();
		logic first;
		rng_state = xorshift(rng_state);
		do_write(make_addr(9'd20, 5'd9, 2'd1), rng_state[15:0]);
		do_write(make_addr(9'd21, 5'd9, 2'd2), rng_state[31:16]);
		do_read("evict third tag", make_addr(9'd22, 5'd9, 2'd0), first);
		do_read("evict fourth tag", make_addr(9'd23, 5'd9, 2'd3), first);
		do_read("evict reload first", make_addr(9'd20, 5'd9, 2'd1), first);
		check_flag("evict reload first went to memory", 1'b0, first);
		do_read("evict reload second", make_addr(9'd21, 5'd9, 2'd2), first);
		check_flag("evict reload second went to memory", 1'b0, first);
	endtask

	// two tag bits and one index bit with the full offset so sets collide often
	task automatic test_random_mix();
		logic [ADDR_W-1:0] addr;
		logic              first;
		for (int i = 0; i < 300; i++) begin
			rng_state = xorshift(rng_state);
			addr = make_addr({7'd0, rng_state[4:3]}, {4'd0, rng_state[2]}, rng_state[1:0]);
			if (rng_state[8])
				do_write(addr, rng_state[31:16]);
			else
				do_read("random_mix", addr, first);
		end
	endtask

	initial begin
		rst       = 1'b1;
		i_re      = 1'b0;
		i_we      = 1'b0;
		i_addr    = '0;
		i_wdata   = '0;
		rng_state = 32'h03e7_7439;
		for (int a = 0; a < 2**ADDR_W; a++) begin
			ref_mem[a] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_after_reset();
		test_store_reload();
		test_word_merge();
		test_lru_choice();
		test_dirty_eviction();
		test_random_mix();

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== dcache_assertions.sv ====
module dcache_assertions (
	input logic                        clk,
	input logic                        rst,
	input logic [dcache_pkg::ST_W-1:0] state,
	input logic                        i_we,
	input logic                        i_hit,
	input logic                        i_mem_done,
	input logic                        o_hit,
	input logic                        o_fill_we,
	input logic                        o_mem_rd,
	input logic                        o_mem_wr
);
	import dcache_pkg::*;

	// one memory access at a time
	mem_strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(o_mem_rd && o_mem_wr))
		else $error("memory read and write strobes high together");

	// set store written only by a finished fill or a store hit
	fill_write_source: assert property (@(posedge clk) disable iff (rst)
		o_fill_we |-> (i_mem_done || (state == ST_IDLE && i_we && i_hit)))
		else $error("fill write outside a memory done cycle or a store hit");

	ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> o_hit)
		else $error("cache not ready in the first cycle after reset");

endmodule

bind dcache_ctrl dcache_assertions dcache_assertions_i (
	.clk        (clk),
	.rst        (rst),
	.state      (state_q),
	.i_we       (i_we),
	.i_hit      (i_hit),
	.i_mem_done (i_mem_done),
	.o_hit      (o_hit),
	.o_fill_we  (o_fill_we),
	.o_mem_rd   (o_mem_rd),
	.o_mem_wr   (o_mem_wr)
);

// ==== dcache_top.sv ====
module dcache_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_re,
	input  logic                         i_we,
	input  logic [dcache_pkg::ADDR_W-1:0] i_addr,
	input  logic [dcache_pkg::WORD_W-1:0] i_wdata,
	output logic [dcache_pkg::WORD_W-1:0] o_rdata,
	output logic                         o_hit
);
	import dcache_pkg::*;

	// controller to set store
	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;
	logic               fill_we;
	logic               fill_way;
	line_t              fill_line;
	logic               fill_dirty;
	logic               touch;
	logic               touch_way;

	// set store lookup results
	logic               hit;
	logic               hit_way;
	line_t              hit_line;
	logic               victim_way;
	logic               victim_valid;
	logic               victim_dirty;
	logic [TAG_W-1:0]   victim_tag;
	line_t              victim_line;

	// memory side
	logic                   mem_rd;
	logic                   mem_wr;
	logic [LINE_ADDR_W-1:0] mem_addr;
	line_t                  mem_wline;
	line_t                  mem_rline;
	logic                   mem_done;

	dcache_ctrl dcache_ctrl_i (
		.clk            (clk),
		.rst            (rst),
		.i_re           (i_re),
		.i_we           (i_we),
		.i_addr         (i_addr),
		.i_wdata        (i_wdata),
		.i_hit          (hit),
		.i_hit_way      (hit_way),
		.i_hit_line     (hit_line),
		.i_victim_way   (victim_way),
		.i_victim_valid (victim_valid),
		.i_victim_dirty (victim_dirty),
		.i_victim_tag   (victim_tag),
		.i_victim_line  (victim_line),
		.i_mem_rline    (mem_rline),
		.i_mem_done     (mem_done),
		.o_rdata        (o_rdata),
		.o_hit          (o_hit),
		.o_index        (index),
		.o_tag          (tag),
		.o_fill_we      (fill_we),
		.o_fill_way     (fill_way),
		.o_fill_line    (fill_line),
		.o_fill_dirty   (fill_dirty),
		.o_touch        (touch),
		.o_touch_way    (touch_way),
		.o_mem_rd       (mem_rd),
		.o_mem_wr       (mem_wr),
		.o_mem_addr     (mem_addr),
		.o_mem_wline    (mem_wline)
	);

	dcache_sets dcache_sets_i (
		.clk            (clk),
		.rst            (rst),
		.i_index        (index),
		.i_tag          (tag),
		.i_fill_we      (fill_we),
		.i_fill_way     (fill_way),
		.i_fill_line    (fill_line),
		.i_fill_dirty   (fill_dirty),
		.i_touch        (touch),
		.i_touch_way    (touch_way),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_hit_line     (hit_line),
		.o_victim_way   (victim_way),
		.o_victim_valid (victim_valid),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag),
		.o_victim_line  (victim_line)
	);

	line_mem line_mem_i (
		.clk         (clk),
		.rst         (rst),
		.i_rd        (mem_rd),
		.i_wr        (mem_wr),
		.i_line_addr (mem_addr),
		.i_wline     (mem_wline),
		.o_rline     (mem_rline),
		.o_done      (mem_done)
	);

endmodule

// ==== line_mem.sv ====
module line_mem (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_rd,
	input  logic                              i_wr,
	input  logic [dcache_pkg::LINE_ADDR_W-1:0] i_line_addr,
	input  dcache_pkg::line_t                 i_wline,
	output dcache_pkg::line_t                 o_rline,
	output logic                              o_done
);
	import dcache_pkg::*;

	line_t                  mem [2**LINE_ADDR_W];
	logic                   busy_q;      // one access in flight
	logic [MEM_CNT_W-1:0]   cnt_q;
	logic [LINE_ADDR_W-1:0] addr_q;
	logic                   accept;

	initial begin
		for (int i = 0; i < 2**LINE_ADDR_W; i++) begin
			mem[i] = '0;
		end
	end

	assign accept = !busy_q && (i_rd || i_wr);

	// delay counter, done after MEM_LATENCY cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (accept) begin
			busy_q <= 1'b1;
			cnt_q  <= MEM_CNT_W'(1);
		end else if (busy_q) begin
			if (o_done)
				busy_q <= 1'b0;
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= i_line_addr;   // read data follows the accepted request
			if (i_wr)
				mem[i_line_addr] <= i_wline;
		end
	end

	assign o_done  = busy_q && (cnt_q == MEM_CNT_W'(MEM_LATENCY));
	assign o_rline = mem[addr_q];

endmodule

// ==== dcache_ctrl.sv ====
module dcache_ctrl (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_re,
	input  logic                              i_we,
	input  logic [dcache_pkg::ADDR_W-1:0]      i_addr,
	input  logic [dcache_pkg::WORD_W-1:0]      i_wdata,
	input  logic                              i_hit,
	input  logic                              i_hit_way,
	input  dcache_pkg::line_t                 i_hit_line,
	input  logic                              i_victim_way,
	input  logic                              i_victim_valid,
	input  logic                              i_victim_dirty,
	input  logic [dcache_pkg::TAG_W-1:0]       i_victim_tag,
	input  dcache_pkg::line_t                 i_victim_line,
	input  dcache_pkg::line_t                 i_mem_rline,
	input  logic                              i_mem_done,
	output logic [dcache_pkg::WORD_W-1:0]      o_rdata,
	output logic                              o_hit,
	output logic [dcache_pkg::INDEX_W-1:0]     o_index,
	output logic [dcache_pkg::TAG_W-1:0]       o_tag,
	output logic                              o_fill_we,
	output logic                              o_fill_way,
	output dcache_pkg::line_t                 o_fill_line,
	output logic                              o_fill_dirty,
	output logic                              o_touch,
	output logic                              o_touch_way,
	output logic                              o_mem_rd,
	output logic                              o_mem_wr,
	output logic [dcache_pkg::LINE_ADDR_W-1:0] o_mem_addr,
	output dcache_pkg::line_t                 o_mem_wline
);
	import dcache_pkg::*;

	logic [ST_W-1:0]     state_q;
	logic [ST_W-1:0]     state_d;
	logic                req;
	logic [OFFSET_W-1:0] offset;
	logic [INDEX_W-1:0]  addr_index;
	logic [TAG_W-1:0]    addr_tag;
	line_t               merged;

	assign req        = i_re | i_we;
	assign offset     = i_addr[OFFSET_W-1:0];
	assign addr_index = i_addr[OFFSET_W +: INDEX_W];
	assign addr_tag   = i_addr[ADDR_W-1 -: TAG_W];

	assign o_index = addr_index;
	assign o_tag   = addr_tag;

	// word select, only meaningful on a read hit
	assign o_rdata = i_hit_line.words[offset];

	// store data replaces one word of the hit line
	always_comb begin
		merged = i_hit_line;
		merged.words[offset] = i_wdata;
	end

	// ready when idle and either nothing is asked or the line is here
	assign o_hit = (state_q == ST_IDLE) && (i_hit || !req);

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d      = state_q;
		o_fill_we    = 1'b0;
		o_fill_way   = i_victim_way;
		o_fill_line  = i_mem_rline;
		o_fill_dirty = 1'b0;
		o_touch      = 1'b0;
		o_touch_way  = i_hit_way;
		o_mem_rd     = 1'b0;
		o_mem_wr     = 1'b0;
		o_mem_addr   = {addr_tag, addr_index};   // fill address
		o_mem_wline  = i_victim_line;

		case (state_q)
			ST_IDLE: begin
				if (req && i_hit) begin
					o_touch = 1'b1;
					if (i_we) begin
						// store hit writes the merged line back dirty
						o_fill_we    = 1'b1;
						o_fill_way   = i_hit_way;
						o_fill_line  = merged;
						o_fill_dirty = 1'b1;
						state_d      = ST_SETTLE;
					end
				end else if (req) begin
					if (i_victim_valid && i_victim_dirty)
						state_d = ST_WB;
					else
						state_d = ST_FILL;
				end
			end
			ST_WB: begin
				o_mem_wr   = 1'b1;
				o_mem_addr = {i_victim_tag, addr_index};   // victim's own line
				if (i_mem_done)
					state_d = ST_FILL;
			end
			ST_FILL: begin
				o_mem_rd = 1'b1;
				if (i_mem_done) begin
					// clean line into the victim way, access retries as a hit
					o_fill_we = 1'b1;
					state_d   = ST_IDLE;
				end
			end
			ST_SETTLE: begin
				state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

endmodule

// ==== dcache_sets.sv ====
module dcache_sets (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [dcache_pkg::INDEX_W-1:0] i_index,
	input  logic [dcache_pkg::TAG_W-1:0]   i_tag,
	input  logic                          i_fill_we,
	input  logic                          i_fill_way,
	input  dcache_pkg::line_t             i_fill_line,
	input  logic                          i_fill_dirty,
	input  logic                          i_touch,
	input  logic                          i_touch_way,
	output logic                          o_hit,
	output logic                          o_hit_way,
	output dcache_pkg::line_t             o_hit_line,
	output logic                          o_victim_way,
	output logic                          o_victim_valid,
	output logic                          o_victim_dirty,
	output logic [dcache_pkg::TAG_W-1:0]   o_victim_tag,
	output dcache_pkg::line_t             o_victim_line
);
	import dcache_pkg::*;

	logic [1:0][N_SETS-1:0] valid_q;
	logic [1:0][N_SETS-1:0] dirty_q;
	logic [N_SETS-1:0]      lru_q;     // way to replace next
	logic [TAG_W-1:0]       tag_q [2][N_SETS];
	line_t                  line_q [2][N_SETS];

	logic [1:0] way_hit;
	logic       victim;

	// status bits
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q   <= '0;
		end else begin
			if (i_fill_we) begin
				valid_q[i_fill_way][i_index] <= 1'b1;
				dirty_q[i_fill_way][i_index] <= i_fill_dirty;
			end
			if (i_touch)
				lru_q[i_index] <= ~i_touch_way;   // other way goes next
		end
	end

	always_ff @(posedge clk) begin
		if (i_fill_we) begin
			tag_q[i_fill_way][i_index]  <= i_tag;
			line_q[i_fill_way][i_index] <= i_fill_line;
		end
	end

	// tag compare in both ways
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[w][i_index] && (tag_q[w][i_index] == i_tag);
		end
	end

	assign o_hit      = |way_hit;
	assign o_hit_way  = way_hit[1];
	assign o_hit_line = line_q[o_hit_way][i_index];

	// empty ways are used before the lru choice
	always_comb begin
		if (!valid_q[0][i_index])
			victim = 1'b0;
		else if (!valid_q[1][i_index])
			victim = 1'b1;
		else
			victim = lru_q[i_index];
	end

	assign o_victim_way   = victim;
	assign o_victim_valid = valid_q[victim][i_index];
	assign o_victim_dirty = dirty_q[victim][i_index];
	assign o_victim_tag   = tag_q[victim][i_index];
	assign o_victim_line  = line_q[victim][i_index];

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

	// address fields, word addressed
	localparam int ADDR_W      = 16;
	localparam int WORD_W      = 16;
	localparam int OFFSET_W    = 2;   // four words per line
	localparam int INDEX_W     = 5;   // 32 sets
	localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
	localparam int LINE_ADDR_W = TAG_W + INDEX_W;

	localparam int LINE_W = WORD_W << OFFSET_W;
	localparam int N_SETS = 1 << INDEX_W;

	// main memory timing
	localparam int MEM_LATENCY = 4;   // request accept to done pulse
	localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);

	// controller states
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;
	localparam logic [ST_W-1:0] ST_WB     = 2'd1;   // dirty victim going out
	localparam logic [ST_W-1:0] ST_FILL   = 2'd2;   // requested line coming in
	localparam logic [ST_W-1:0] ST_SETTLE = 2'd3;   // one cycle after a store hit

	// one cache line, seen either as a flat vector for storage and memory
	// transfer or as words picked by the word offset
	// word 0 sits in the low bits
	typedef union packed {
		logic [LINE_W-1:0]                    flat;
		logic [2**OFFSET_W-1:0][WORD_W-1:0]  words;
	} line_t;

endpackage
